//--- source/audio_pkg.sv
package audio_pkg;

    ////////////////////////////////////////////////////////////
    // sample and frame format
    ////////////////////////////////////////////////////////////
    localparam int sample_width    = 24;  // pcm word
    localparam int slot_bits       = 32;  // bclks per channel slot

    ////////////////////////////////////////////////////////////
    // filter bank
    ////////////////////////////////////////////////////////////
    localparam int num_filters     = 2;   // eq bands
    localparam int fir_taps        = 4;   // taps per band
    localparam int coef_width      = 16;  // signed q1.15
    localparam int coef_frac       = 15;  // fraction bits of a coefficient
    localparam int acc_width       = 48;  // per band accumulator
    localparam int coef_addr_width = 3;   // num_filters * fir_taps entries

    ////////////////////////////////////////////////////////////
    // equalizer gains
    ////////////////////////////////////////////////////////////
    localparam int gain_width      = 16;  // unsigned q8.8
    localparam int gain_frac       = 8;   // fraction bits of a gain
    localparam int gain_addr_width = 1;   // one entry per band

    // dac side bit clock
    localparam int bclk_div        = 2;   // sys clks per half bclk

endpackage

//--- source/i2s_receiver.sv
module i2s_receiver (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               i2s_bclk,
    input  logic                               i2s_lrclk,
    input  logic                               i2s_d,
    output logic                               pcm_valid,
    output logic [audio_pkg::sample_width-1:0] l_pcm,
    output logic [audio_pkg::sample_width-1:0] r_pcm
);

    localparam int cnt_width = $clog2(audio_pkg::slot_bits);

    logic [2:0]                         pin_meta;    // {bclk, lrclk, d}, first flop
    logic [2:0]                         pin_sync;    // second flop
    logic                               bclk_last;   // for edge detect
    logic                               lr_last;     // lrclk seen at last bclk rise
    logic                               bclk_rise;
    logic                               lr_change;
    logic [cnt_width-1:0]               bit_cnt;     // bit position in slot
    logic [audio_pkg::sample_width-1:0] shift_word;

    assign bclk_rise = pin_sync[2] && !bclk_last;
    assign lr_change = pin_sync[1] != lr_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            pin_meta  <= '0;
            pin_sync  <= '0;
            bclk_last <= 1'b0;
            lr_last   <= 1'b0;
            bit_cnt   <= '0;
            pcm_valid <= 1'b0;
        end else begin
            pin_meta  <= {i2s_bclk, i2s_lrclk, i2s_d};
            pin_sync  <= pin_meta;
            bclk_last <= pin_sync[2];
            pcm_valid <= 1'b0;
            if (bclk_rise) begin
                lr_last <= pin_sync[1];
                if (lr_change) begin
                    bit_cnt   <= '0;            // msb comes on next bclk
                    pcm_valid <= !pin_sync[1];  // right slot just finished
                end else if (bit_cnt != cnt_width'(audio_pkg::slot_bits - 1)) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    // data capture and word latching
    always_ff @(posedge clk) begin
        if (bclk_rise) begin
            if (lr_change) begin
                if (pin_sync[1])
                    l_pcm <= shift_word;  // left word done
                else
                    r_pcm <= shift_word;  // right word done
            end else if (bit_cnt < cnt_width'(audio_pkg::sample_width)) begin
                shift_word <= {shift_word[audio_pkg::sample_width-2:0], pin_sync[0]};
            end
        end
    end

endmodule

//--- source/fir_filter_bank.sv
module fir_filter_bank (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      enable,
    input  logic                                      coef_wr_en,
    input  logic                                      coef_addr_reset,
    input  logic signed [audio_pkg::coef_width-1:0]   coef_wr_data,
    input  logic                                      pcm_valid,
    input  logic signed [audio_pkg::sample_width-1:0] l_pcm,
    input  logic signed [audio_pkg::sample_width-1:0] r_pcm,
    output logic                                      coef_addr_zero,
    output logic                                      l_fir_valid,
    output logic                                      r_fir_valid,
    output logic signed [audio_pkg::acc_width-1:0]    l_band_0,
    output logic signed [audio_pkg::acc_width-1:0]    l_band_1,
    output logic signed [audio_pkg::acc_width-1:0]    r_band_0,
    output logic signed [audio_pkg::acc_width-1:0]    r_band_1
);

    localparam int coef_entries = audio_pkg::num_filters * audio_pkg::fir_taps;
    localparam int tap_bits     = $clog2(audio_pkg::fir_taps);
    localparam int step_bits    = audio_pkg::coef_addr_width + 1;  // channel on top

    logic signed [audio_pkg::coef_width-1:0]   coef_mem [coef_entries];
    logic [audio_pkg::coef_addr_width-1:0]     coef_addr;
    logic signed [audio_pkg::sample_width-1:0] l_hist [audio_pkg::fir_taps];
    logic signed [audio_pkg::sample_width-1:0] r_hist [audio_pkg::fir_taps];
    logic                                      busy;
    logic [step_bits-1:0]                      step;   // {chan, band, tap}
    logic [tap_bits-1:0]                       tap;
    logic signed [audio_pkg::sample_width-1:0] hist_tap;
    logic signed [audio_pkg::sample_width+audio_pkg::coef_width-1:0] mult;
    logic signed [audio_pkg::acc_width-1:0]    acc;
    logic signed [audio_pkg::acc_width-1:0]    band_q [2*audio_pkg::num_filters];

    ////////////////////////////////////////////////////////////
    // coefficient table, host side
    ////////////////////////////////////////////////////////////
    assign coef_addr_zero = coef_addr == '0;

    always_ff @(posedge clk) begin
        if (reset || coef_addr_reset)
            coef_addr <= '0;
        else if (coef_wr_en)
            coef_addr <= (coef_addr == audio_pkg::coef_addr_width'(coef_entries - 1)) ?
                         '0 : coef_addr + 1'b1;  // wrap after last entry
    end

    always_ff @(posedge clk) begin
        if (coef_wr_en)
            coef_mem[coef_addr] <= coef_wr_data;
    end

    // sample history, newest in slot 0
    always_ff @(posedge clk) begin
        if (reset || !enable) begin
            for (int k = 0; k < audio_pkg::fir_taps; k++) begin
                l_hist[k] <= '0;
                r_hist[k] <= '0;
            end
        end else if (pcm_valid) begin
            l_hist[0] <= l_pcm;
            r_hist[0] <= r_pcm;
            for (int k = 1; k < audio_pkg::fir_taps; k++) begin
                l_hist[k] <= l_hist[k-1];
                r_hist[k] <= r_hist[k-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // sequential mac, one tap per clock
    ////////////////////////////////////////////////////////////
    assign tap      = step[tap_bits-1:0];
    assign hist_tap = step[step_bits-1] ? r_hist[tap] : l_hist[tap];
    assign mult     = hist_tap * coef_mem[step[audio_pkg::coef_addr_width-1:0]];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy        <= 1'b0;
            step        <= '0;
            l_fir_valid <= 1'b0;
            r_fir_valid <= 1'b0;
        end else begin
            l_fir_valid <= busy && step == step_bits'(coef_entries - 1);      // left bands done
            r_fir_valid <= busy && step == step_bits'(2 * coef_entries - 1);  // right bands done
            if (pcm_valid) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == step_bits'(2 * coef_entries - 1))
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            acc <= (tap == '0) ? mult : acc + mult;  // restart per band
            if (tap == tap_bits'(audio_pkg::fir_taps - 1))
                band_q[step[step_bits-1:tap_bits]] <= acc + mult;
        end
    end

    assign l_band_0 = band_q[0];
    assign l_band_1 = band_q[1];
    assign r_band_0 = band_q[2];
    assign r_band_1 = band_q[3];

    // next sample must find the sequencer idle
    assert property (@(posedge clk) disable iff (reset) pcm_valid |-> !busy)
        else $error("pcm_valid while filter sequencer busy");
    assert property (@(posedge clk) disable iff (reset)
        (l_fir_valid || r_fir_valid) |=> !(l_fir_valid || r_fir_valid))
        else $error("fir valids high in consecutive cycles");

endmodule

//--- source/equalizer_gains.sv
module equalizer_gains (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      eq_bypass,
    input  logic                                      eq_wr_en,
    input  logic [audio_pkg::gain_width-1:0]          eq_wr_data,
    input  logic                                      l_fir_valid,
    input  logic                                      r_fir_valid,
    input  logic signed [audio_pkg::acc_width-1:0]    l_band_0,
    input  logic signed [audio_pkg::acc_width-1:0]    l_band_1,
    input  logic signed [audio_pkg::acc_width-1:0]    r_band_0,
    input  logic signed [audio_pkg::acc_width-1:0]    r_band_1,
    output logic                                      eq_addr_zero,
    output logic                                      l_eq_valid,
    output logic                                      r_eq_valid,
    output logic signed [audio_pkg::sample_width-1:0] l_eq,
    output logic signed [audio_pkg::sample_width-1:0] r_eq
);

    localparam int wide = audio_pkg::acc_width + audio_pkg::gain_width + 1;
    localparam logic signed [wide-1:0] pos_max = 2 ** (audio_pkg::sample_width - 1) - 1;
    localparam logic signed [wide-1:0] neg_max = -(2 ** (audio_pkg::sample_width - 1));

    logic [audio_pkg::gain_width-1:0]          gain_mem [audio_pkg::num_filters];
    logic [audio_pkg::gain_addr_width-1:0]     gain_addr;
    logic signed [audio_pkg::acc_width-1:0]    band_sel [audio_pkg::num_filters];
    logic signed [wide-1:0]                    filt_0;  // band 0 back at sample scale
    logic signed [wide-1:0]                    eq_sum;
    logic signed [audio_pkg::sample_width-1:0] eq_out;

    function automatic logic signed [audio_pkg::sample_width-1:0] saturate(
        input logic signed [wide-1:0] v
    );
        if (v > pos_max)
            return pos_max[audio_pkg::sample_width-1:0];
        else if (v < neg_max)
            return neg_max[audio_pkg::sample_width-1:0];
        return v[audio_pkg::sample_width-1:0];
    endfunction

    // gain table, same auto increment scheme as the coefficients
    assign eq_addr_zero = gain_addr == '0;

    always_ff @(posedge clk) begin
        if (reset)
            gain_addr <= '0;
        else if (eq_wr_en)
            gain_addr <= (gain_addr == audio_pkg::gain_addr_width'(audio_pkg::num_filters - 1)) ?
                         '0 : gain_addr + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (eq_wr_en)
            gain_mem[gain_addr] <= eq_wr_data;
    end

    ////////////////////////////////////////////////////////////
    // shared scaling path, left and right never valid together
    ////////////////////////////////////////////////////////////
    always_comb begin
        band_sel[0] = r_fir_valid ? r_band_0 : l_band_0;
        band_sel[1] = r_fir_valid ? r_band_1 : l_band_1;
        filt_0      = band_sel[0] >>> audio_pkg::coef_frac;
        eq_sum      = '0;
        for (int b = 0; b < audio_pkg::num_filters; b++) begin
            eq_sum = eq_sum + (((band_sel[b] >>> audio_pkg::coef_frac) *
                     $signed({1'b0, gain_mem[b]})) >>> audio_pkg::gain_frac);
        end
        eq_out = eq_bypass ? saturate(filt_0) : saturate(eq_sum);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            l_eq_valid <= 1'b0;
            r_eq_valid <= 1'b0;
        end else begin
            l_eq_valid <= l_fir_valid;
            r_eq_valid <= r_fir_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (l_fir_valid)
            l_eq <= eq_out;
        if (r_fir_valid)
            r_eq <= eq_out;
    end

endmodule

//--- source/i2s_transmitter.sv
module i2s_transmitter (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               enable,
    input  logic                               bypass,
    input  logic                               pcm_valid,
    input  logic [audio_pkg::sample_width-1:0] l_pcm,
    input  logic [audio_pkg::sample_width-1:0] r_pcm,
    input  logic                               l_eq_valid,
    input  logic                               r_eq_valid,
    input  logic [audio_pkg::sample_width-1:0] l_eq,
    input  logic [audio_pkg::sample_width-1:0] r_eq,
    output logic                               dac_bclk,
    output logic                               dac_lrclk,
    output logic                               dac_data
);

    localparam int frame_bits = 2 * audio_pkg::slot_bits;
    localparam int pad_bits   = audio_pkg::slot_bits - audio_pkg::sample_width;
    localparam int div_width  = $clog2(audio_pkg::bclk_div);

    logic [div_width-1:0]               div_cnt;
    logic                               div_tick;     // half bclk elapsed
    logic                               bclk_fall;
    logic                               frame_start;  // lrclk about to fall
    logic [$clog2(frame_bits)-1:0]      bit_idx;
    logic [$clog2(frame_bits)-1:0]      bit_next;
    logic [frame_bits-1:0]              frame_shift;
    logic [frame_bits-1:0]              next_frame;
    logic [audio_pkg::sample_width-1:0] l_stage;      // left eq word waiting for right
    logic [audio_pkg::sample_width-1:0] pair_l;
    logic [audio_pkg::sample_width-1:0] pair_r;
    logic                               l_seen;

    ////////////////////////////////////////////////////////////
    // source select and pair hold
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            pair_l <= '0;
            pair_r <= '0;
            l_seen <= 1'b0;
        end else if (bypass) begin
            if (pcm_valid) begin
                pair_l <= l_pcm;  // receiver pair straight through
                pair_r <= r_pcm;
            end
        end else begin
            if (l_eq_valid) begin
                l_stage <= l_eq;
                l_seen  <= 1'b1;
            end
            if (r_eq_valid) begin
                pair_l <= l_stage;  // pair swaps in whole
                pair_r <= r_eq;
                l_seen <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // bit clock, frame counter and serializer
    ////////////////////////////////////////////////////////////
    assign div_tick    = div_cnt == div_width'(audio_pkg::bclk_div - 1);
    assign bclk_fall   = div_tick && dac_bclk;
    assign bit_next    = bit_idx + 1'b1;
    assign frame_start = bclk_fall && bit_idx == '1;
    assign next_frame  = enable ? {pair_l, {pad_bits{1'b0}}, pair_r, {pad_bits{1'b0}}} : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            bit_idx     <= '0;
            dac_bclk    <= 1'b0;
            dac_lrclk   <= 1'b0;
            dac_data    <= 1'b0;
            frame_shift <= '0;
        end else begin
            div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
            if (div_tick)
                dac_bclk <= !dac_bclk;
            if (bclk_fall) begin
                bit_idx     <= bit_next;
                dac_lrclk   <= bit_next[$clog2(frame_bits)-1];   // high for right slot
                dac_data    <= frame_shift[frame_bits-1];        // one bit behind lrclk
                frame_shift <= frame_start ? next_frame : frame_shift << 1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) (r_eq_valid && !bypass) |-> l_seen)
        else $error("right eq word without a left one");

endmodule

//--- source/audio_processing.sv
module audio_processing (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             enable,
    input  logic                             bypass,
    input  logic                             eq_bypass,
    input  logic                             i2s_bclk,
    input  logic                             i2s_lrclk,
    input  logic                             i2s_d,
    input  logic                             coef_wr_en,
    input  logic                             coef_addr_reset,
    input  logic [audio_pkg::coef_width-1:0] coef_wr_data,
    input  logic                             eq_wr_en,
    input  logic [audio_pkg::gain_width-1:0] eq_wr_data,
    output logic                             coef_addr_zero,
    output logic                             eq_addr_zero,
    output logic                             dac_bclk,
    output logic                             dac_lrclk,
    output logic                             dac_data
);

    logic                               pcm_valid;
    logic [audio_pkg::sample_width-1:0] l_pcm, r_pcm;
    logic                               l_fir_valid, r_fir_valid;
    logic [audio_pkg::acc_width-1:0]    l_band_0, l_band_1, r_band_0, r_band_1;
    logic                               l_eq_valid, r_eq_valid;
    logic [audio_pkg::sample_width-1:0] l_eq, r_eq;

    i2s_receiver rx (                            // decode
        .clk, .reset, .i2s_bclk, .i2s_lrclk, .i2s_d,
        .pcm_valid, .l_pcm, .r_pcm
    );

    fir_filter_bank fir (                        // execute, filtering
        .clk, .reset, .enable, .coef_wr_en, .coef_addr_reset, .coef_wr_data,
        .pcm_valid, .l_pcm, .r_pcm, .coef_addr_zero, .l_fir_valid, .r_fir_valid,
        .l_band_0, .l_band_1, .r_band_0, .r_band_1
    );

    equalizer_gains eq (                         // execute, band weighting
        .clk, .reset, .eq_bypass, .eq_wr_en, .eq_wr_data, .l_fir_valid, .r_fir_valid,
        .l_band_0, .l_band_1, .r_band_0, .r_band_1,
        .eq_addr_zero, .l_eq_valid, .r_eq_valid, .l_eq, .r_eq
    );

    i2s_transmitter tx (                         // result, dac side
        .clk, .reset, .enable, .bypass, .pcm_valid, .l_pcm, .r_pcm,
        .l_eq_valid, .r_eq_valid, .l_eq, .r_eq, .dac_bclk, .dac_lrclk, .dac_data
    );

endmodule

//--- tb/audio_model_checks.svh
`ifndef AUDIO_MODEL_CHECKS_SVH
`define AUDIO_MODEL_CHECKS_SVH

localparam int sw = audio_pkg::sample_width;
localparam int taps = audio_pkg::fir_taps;

int          sample_errors = 0;
int          flag_errors = 0;
int          other_errors = 0;
logic [31:0] rng_state = 32'h51b4;
longint      coef_tab [audio_pkg::num_filters*taps];  // host view of the tables
longint      gain_tab [audio_pkg::num_filters];
longint      hist [2][taps];                          // [chan][tap], newest at 0
bit          model_eq_bypass = 1'b0;

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
endfunction

// clip to signed sample range
function automatic logic [sw-1:0] clip(input longint v);
    longint hi;
    longint lo;
    hi = (longint'(1) << (sw - 1)) - 1;
    lo = -hi - 1;
    if (v > hi)
        return hi[sw-1:0];
    else if (v < lo)
        return lo[sw-1:0];
    return v[sw-1:0];
endfunction

////////////////////////////////////////////////////////////
// filter then gain, per channel
////////////////////////////////////////////////////////////
function automatic logic [sw-1:0] channel_out(input int ch);
    longint acc;
    longint filt;
    longint sum;
    longint band0;
    sum = 0;
    band0 = 0;
    for (int b = 0; b < audio_pkg::num_filters; b++) begin
        acc = 0;
        for (int t = 0; t < taps; t++)
            acc = acc + hist[ch][t] * coef_tab[b*taps+t];
        filt = acc >>> 15;                   // back to q0 sample scale
        if (b == 0)
            band0 = filt;
        sum = sum + ((filt * gain_tab[b]) >>> 8);  // q8.8 gain
    end
    return model_eq_bypass ? clip(band0) : clip(sum);
endfunction

function automatic logic [2*sw-1:0] model_pair(input logic [sw-1:0] l, input logic [sw-1:0] r);
    for (int t = taps - 1; t > 0; t--) begin
        hist[0][t] = hist[0][t-1];
        hist[1][t] = hist[1][t-1];
    end
    hist[0][0] = longint'($signed(l));
    hist[1][0] = longint'($signed(r));
    return {channel_out(0), channel_out(1)};
endfunction

task automatic model_clear();
    for (int t = 0; t < taps; t++) begin
        hist[0][t] = 0;
        hist[1][t] = 0;
    end
endtask

task automatic check_sample(input string name, input logic [sw-1:0] got,
                            input logic [sw-1:0] exp);
    if (got !== exp) begin
        sample_errors++;
        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        flag_errors++;
        $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
endtask

`endif

//--- tb/audio_processing_tb.sv
module audio_processing_tb;

    localparam int frame_clks  = 2 * audio_pkg::slot_bits * 4;  // 4 clks per bit
    localparam int test_frames = 12 + 16 + 12 + 6 + 12 + 5 * 8;  // pairs plus idle per phase

    logic clk = 1'b0;
    logic reset, enable, bypass, eq_bypass;
    logic i2s_bclk, i2s_lrclk, i2s_d;
    logic coef_wr_en, coef_addr_reset, eq_wr_en;
    logic [audio_pkg::coef_width-1:0] coef_wr_data;
    logic [audio_pkg::gain_width-1:0] eq_wr_data;
    logic coef_addr_zero, eq_addr_zero, dac_bclk, dac_lrclk, dac_data;

    logic [2*audio_pkg::sample_width-1:0] stim_q [$];  // pairs for the i2s driver
    logic [2*audio_pkg::sample_width-1:0] exp_q [$];   // expected dac pairs
    logic [2*audio_pkg::sample_width-1:0] prev_frame;
    logic [63:0] dac_bits;
    bit          silence = 1'b0;
    bit          bclk_q = 1'b0;
    bit          lr_q = 1'b0;
    int          rise_cnt = -1000;

    `include "audio_model_checks.svh"

    always #10 clk = ~clk;

    audio_processing UUT (
        .clk, .reset, .enable, .bypass, .eq_bypass, .i2s_bclk, .i2s_lrclk, .i2s_d,
        .coef_wr_en, .coef_addr_reset, .coef_wr_data, .eq_wr_en, .eq_wr_data,
        .coef_addr_zero, .eq_addr_zero, .dac_bclk, .dac_lrclk, .dac_data
    );

    ////////////////////////////////////////////////////////////
    // i2s source, zero frames when nothing queued
    ////////////////////////////////////////////////////////////
    initial begin
        logic [63:0] word;
        i2s_bclk  <= 1'b0;
        i2s_lrclk <= 1'b0;
        i2s_d     <= 1'b0;
        forever begin
            word = '0;
            if (stim_q.size() > 0)
                word = {stim_q[0][47:24], 8'h00, stim_q[0][23:0], 8'h00};
            if (stim_q.size() > 0)
                void'(stim_q.pop_front());
            for (int i = 0; i < 64; i++) begin
                @(posedge clk);
                i2s_bclk  <= 1'b0;
                i2s_lrclk <= i >= 32;
                i2s_d     <= (i == 0) ? 1'b0 : word[64-i];  // one bit behind lrclk
                @(posedge clk);
                @(posedge clk);
                i2s_bclk <= 1'b1;
                @(posedge clk);
            end
        end
    end

    task automatic take_frame(input logic [23:0] l, input logic [23:0] r);
        logic [47:0] exp;
        if ({l, r} == prev_frame)
            return;                           // repeat of last pair
        prev_frame = {l, r};
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            check_sample("dac left", l, exp[47:24]);
            check_sample("dac right", r, exp[23:0]);
        end else if (silence && {l, r} != '0) begin
            other_errors++;
            $display("DAC sent a nonzero frame while enable was low at %0t", $time);
        end
    endtask

    // dac decoder, bits taken on rising dac_bclk
    always @(negedge clk) begin
        if (reset) begin
            rise_cnt = -1000;
            lr_q = 1'b0;
        end else if (dac_bclk && !bclk_q) begin
            dac_bits = {dac_bits[62:0], dac_data};
            if (!dac_lrclk && lr_q) begin
                if (rise_cnt == 63)
                    take_frame(dac_bits[63:40], dac_bits[31:8]);
                rise_cnt = 0;
            end else begin
                rise_cnt++;
            end
            lr_q = dac_lrclk;
        end
        bclk_q = dac_bclk;
    end

    initial begin
        repeat ((test_frames + 20) * frame_clks) @(posedge clk);
        $display("timeout, expected DAC frames did not all arrive");
        $display("errors: sample %0d, flag %0d, other %0d",
                 sample_errors, flag_errors, other_errors);
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // sequence helpers
    ////////////////////////////////////////////////////////////
    task automatic start_phase(input bit byp, input bit eqb, input bit en);
        @(posedge clk);
        reset     <= 1'b1;
        bypass    <= byp;
        eq_bypass <= eqb;
        enable    <= en;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        model_eq_bypass = eqb;
        model_clear();
        prev_frame = '0;
        repeat (2 * frame_clks) @(posedge clk);
    endtask

    task automatic run_pairs(input int n, input bit direct);
        logic [23:0] l;
        logic [23:0] r;
        logic [31:0] rnd;
        for (int k = 0; k < n; k++) begin      // all in one step, no idle gaps
            rnd = next_rand();
            l = rnd[23:0];
            rnd = next_rand();
            r = rnd[23:0];
            stim_q.push_back({l, r});
            exp_q.push_back(direct ? {l, r} : model_pair(l, r));
        end
        while (exp_q.size() > 0)
            @(negedge clk);
        repeat (2 * frame_clks) @(posedge clk);
    endtask

    task automatic write_coef(input longint v, input bit zero_after);
        @(posedge clk);
        coef_wr_en   <= 1'b1;
        coef_wr_data <= v[15:0];
        @(posedge clk);
        coef_wr_en <= 1'b0;
        @(negedge clk);
        check_flag("coef_addr_zero", coef_addr_zero, zero_after);
    endtask

    task automatic write_gain(input longint v, input bit zero_after);
        @(posedge clk);
        eq_wr_en   <= 1'b1;
        eq_wr_data <= v[15:0];
        @(posedge clk);
        eq_wr_en <= 1'b0;
        @(negedge clk);
        check_flag("eq_addr_zero", eq_addr_zero, zero_after);
    endtask

    initial begin
        logic [31:0] rnd_l;
        logic [31:0] rnd_r;
        reset           <= 1'b1;
        enable          <= 1'b1;
        bypass          <= 1'b0;
        eq_bypass       <= 1'b0;
        coef_wr_en      <= 1'b0;
        coef_addr_reset <= 1'b0;
        coef_wr_data    <= '0;
        eq_wr_en        <= 1'b0;
        eq_wr_data      <= '0;

        start_phase(1'b1, 1'b0, 1'b1);
        run_pairs(12, 1'b1);                  // bypass, pairs pass straight

        @(negedge clk);
        check_flag("coef_addr_zero", coef_addr_zero, 1'b1);
        check_flag("eq_addr_zero", eq_addr_zero, 1'b1);
        for (int i = 0; i < 3; i++)
            write_coef(longint'(next_rand() % 32'd8191) - 4095, 1'b0);
        @(posedge clk);
        coef_addr_reset <= 1'b1;              // back to entry 0 mid table
        @(posedge clk);
        coef_addr_reset <= 1'b0;
        @(negedge clk);
        check_flag("coef_addr_zero", coef_addr_zero, 1'b1);
        for (int i = 0; i < 8; i++) begin
            coef_tab[i] = longint'(next_rand() % 32'd8191) - 4095;
            write_coef(coef_tab[i], i == 7);
        end
        for (int i = 0; i < 2; i++) begin
            gain_tab[i] = longint'(next_rand() % 32'd4096);
            write_gain(gain_tab[i], i == 1);
        end

        start_phase(1'b0, 1'b0, 1'b1);
        run_pairs(16, 1'b0);                  // filter, gain, sum
        start_phase(1'b0, 1'b1, 1'b1);
        run_pairs(12, 1'b0);                  // band 0 only

        start_phase(1'b1, 1'b0, 1'b0);        // bypass pairs reach the dac gate
        silence = 1'b1;
        for (int k = 0; k < 6; k++) begin
            rnd_l = next_rand();
            rnd_r = next_rand();
            stim_q.push_back({rnd_l[23:0], rnd_r[23:0]});
        end
        while (stim_q.size() > 0)
            @(negedge clk);
        @(posedge clk);
        bypass <= 1'b0;                       // last pairs take the filter path
        repeat (frame_clks + 32) @(posedge clk);
        silence = 1'b0;
        enable <= 1'b1;
        model_clear();                        // history restarts empty
        run_pairs(12, 1'b0);

        $display("errors: sample %0d, flag %0d, other %0d",
                 sample_errors, flag_errors, other_errors);
        if (sample_errors + flag_errors + other_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

//--- all.f
+incdir+tb
source/audio_pkg.sv
source/i2s_receiver.sv
source/fir_filter_bank.sv
source/equalizer_gains.sv
source/i2s_transmitter.sv
source/audio_processing.sv
tb/audio_processing_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := audio_processing_tb
FILELIST  := all.f
LOG       := sim.log
PASS_TEXT := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
